// ==== hw/dram_settings.svh ====
`ifndef DRAM_SETTINGS_SVH
`define DRAM_SETTINGS_SVH

// every timing value is in controller clock cycles

// power-up wait before the first command
`define tINIT 40
// activate to read or write
`define tRCD 4
// minimum activate to precharge
`define tRAS 12
// read and write latency to the first data beat
`define tRL 5
`define tWL 4
// data beats per burst
`define tBURST 4
// write recovery before precharge
`define tWR 4
// precharge period
`define tRP 4
// refresh cycle time
`define tRFC 20
// average refresh interval
`define tREFI 200

// down-counter and refresh counter width
`define CNT_W 10
// request field widths
`define BANK_W 2
`define ROW_W 14
`define COL_W 10

`endif

// ==== hw/dram_cmd_pkg.sv ====
`include "dram_settings.svh"

package dram_cmd_pkg;

    // shared width of the wait counter and the refresh registers
    typedef logic [`CNT_W-1:0] cnt_t;

    // each command has an issue state of one cycle and a wait state after it
    typedef enum logic [3:0] {
        POWERUP     = 4'd0,
        IDLE        = 4'd1,
        ACTIVATE    = 4'd2,
        ACTIVATING  = 4'd3,
        READ        = 4'd4,
        READING     = 4'd5,
        WRITE       = 4'd6,
        WRITING     = 4'd7,
        PRECHARGE   = 4'd8,
        PRECHARGING = 4'd9,
        REFRESH     = 4'd10,
        REFRESHING  = 4'd11
    } cmd_state_t;

    // command on the DRAM pins, NOP between commands
    typedef enum logic [2:0] {
        NOP = 3'd0,
        ACT = 3'd1,
        RD  = 3'd2,
        WR  = 3'd3,
        PRE = 3'd4,
        REF = 3'd5
    } dram_cmd_t;

endpackage

// ==== hw/dram_host_pkg.sv ====
`include "dram_settings.svh"

package dram_host_pkg;

    // byte addresses on the 8-bit APB address
    localparam logic [7:0] REQ_ADDR    = 8'h00;
    localparam logic [7:0] STATUS_ADDR = 8'h04;

    // STATUS bit positions
    localparam int STAT_INIT = 0;
    localparam int STAT_BUSY = 1;
    localparam int STAT_RFSH = 2;

    // one access request
    // in PWDATA from bit 0 up: col, row, bank, is_write
    typedef struct packed {
        logic              is_write;
        logic [`BANK_W-1:0] bank;
        logic [`ROW_W-1:0]  row;
        logic [`COL_W-1:0]  col;
    } dram_req_t;

    // 27 bits with the default widths
    localparam int REQ_W = $bits(dram_req_t);

endpackage

// ==== hw/timing_signal_if.sv ====
`timescale 1ns/100ps

interface timing_signal_if;

    // wait-state done flags, each high for one cycle
    logic tINIT_done;
    logic tACT_done;
    logic tRD_done;
    logic tWR_done;
    logic tPRE_done;
    logic tREF_done;

    // refresh interval reached, serve before new accesses
    logic rf_req;

    // data strobe windows
    logic rd_en;
    logic wr_en;

    // sticky once the power-up wait is over
    logic init_done;

    modport timing_ctrl (
        output tINIT_done, tACT_done, tRD_done, tWR_done, tPRE_done, tREF_done,
        output rf_req, rd_en, wr_en, init_done
    );

    modport cmd_ctrl (
        input tINIT_done, tACT_done, tRD_done, tWR_done, tPRE_done, tREF_done,
        input rf_req
    );

endinterface

// ==== hw/command_fsm_if.sv ====
`timescale 1ns/100ps

interface command_fsm_if;
    import dram_cmd_pkg::*;
    import dram_host_pkg::*;

    // current sequencer state
    cmd_state_t cmd_state;

    // pending request, stable while req_valid is high
    dram_req_t req;
    logic      req_valid;
    // one-cycle pulse as IDLE moves to ACTIVATE
    logic      req_take;

    modport fsm (output cmd_state, req_take, input req, req_valid);

    modport timing_ctrl (input cmd_state);

    // busy status also needs the state
    modport host_port (output req_valid, req, input req_take, cmd_state);

endinterface

// ==== hw/flex_counter.sv ====
`timescale 1ns/100ps
`include "dram_settings.svh"

module flex_counter #(
    parameter int N = `CNT_W
) (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         enable,
    input  logic         clear,
    input  logic [N-1:0] count_load,
    output logic [N-1:0] count,
    output logic         count_done
);

    logic [N-1:0] next_count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

    always_comb begin
        next_count = count;
        if (clear) begin
            next_count = '0;
        end else if (enable) begin
            next_count = count_load;
        end else if (count > N'(1)) begin
            // run down and park at one, zero stays zero
            next_count = count - N'(1);
        end
    end

    assign count_done = (count == N'(1));

    // load and clear come from different states
    ap_no_load_and_clear: assert property (@(posedge CLK) disable iff (!nRST)
        !(enable && clear))
        else $error("flex_counter: enable and clear together");

endmodule

// ==== hw/timing_signal.sv ====
`timescale 1ns/100ps
`include "dram_settings.svh"

module timing_signal (
    input logic                  CLK,
    input logic                  nRST,
    timing_signal_if.timing_ctrl timif,
    command_fsm_if.timing_ctrl   cfsmif
);
    import dram_cmd_pkg::*;

    // shared wait counter
    cnt_t time_load;
    cnt_t time_count;
    logic time_en;
    logic time_clear;
    logic time_done;

    // refresh interval tracking
    cnt_t refresh_count;
    cnt_t next_refresh_count;
    cnt_t refresh_limit;
    cnt_t next_refresh_limit;
    cnt_t lateness;
    logic in_refresh;

    flex_counter #(.N(`CNT_W)) u_time_counter (
        .CLK        (CLK),
        .nRST       (nRST),
        .enable     (time_en),
        .clear      (time_clear),
        .count_load (time_load),
        .count      (time_count),
        .count_done (time_done)
    );

    // issue states load the wait length, wait states report done
    always_comb begin
        time_en = 1'b0;
        time_clear = 1'b0;
        time_load = '0;
        timif.tINIT_done = 1'b0;
        timif.tACT_done = 1'b0;
        timif.tRD_done = 1'b0;
        timif.tWR_done = 1'b0;
        timif.tPRE_done = 1'b0;
        timif.tREF_done = 1'b0;
        case (cfsmif.cmd_state)
            POWERUP: begin
                // counter is zero only in the first cycle after reset
                if (time_count == '0) begin
                    time_en = 1'b1;
                    time_load = cnt_t'(`tINIT);
                end
                timif.tINIT_done = time_done;
            end
            // park at zero so no done flag lingers
            IDLE: time_clear = 1'b1;
            ACTIVATE: begin
                time_en = 1'b1;
                time_load = cnt_t'(`tRCD);
            end
            ACTIVATING: timif.tACT_done = time_done;
            READ: begin
                time_en = 1'b1;
                time_load = cnt_t'(`tRL + `tBURST);
            end
            READING: timif.tRD_done = time_done;
            WRITE: begin
                time_en = 1'b1;
                // write recovery rides on the same wait
                time_load = cnt_t'(`tWL + `tBURST + `tWR);
            end
            WRITING: timif.tWR_done = time_done;
            PRECHARGE: begin
                time_en = 1'b1;
                time_load = cnt_t'(`tRP);
            end
            PRECHARGING: timif.tPRE_done = time_done;
            REFRESH: begin
                time_en = 1'b1;
                time_load = cnt_t'(`tRFC);
            end
            REFRESHING: timif.tREF_done = time_done;
            default: begin
            end
        endcase
    end

    // count is L+1-k in wait cycle k
    // read beats in cycles tRL+1 .. tRL+tBURST after RD
    assign timif.rd_en = (cfsmif.cmd_state == READING)
                       && (time_count <= cnt_t'(`tBURST));
    // write beats in cycles tWL+1 .. tWL+tBURST after WR, tWR left after them
    assign timif.wr_en = (cfsmif.cmd_state == WRITING)
                       && (time_count > cnt_t'(`tWR))
                       && (time_count <= cnt_t'(`tWR + `tBURST));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            timif.init_done <= 1'b0;
        end else if (timif.tINIT_done) begin
            timif.init_done <= 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            refresh_count <= '0;
            refresh_limit <= cnt_t'(`tREFI);
        end else begin
            refresh_count <= next_refresh_count;
            refresh_limit <= next_refresh_limit;
        end
    end

    assign in_refresh = (cfsmif.cmd_state == REFRESH) || (cfsmif.cmd_state == REFRESHING);

    // the normal response is one cycle after rf_req, anything beyond is late
    assign lateness = refresh_count - refresh_limit - cnt_t'(1);

    always_comb begin
        next_refresh_count = refresh_count;
        if (in_refresh) begin
            next_refresh_count = '0;
        end else if (timif.init_done) begin
            next_refresh_count = refresh_count + cnt_t'(1);
        end

        next_refresh_limit = refresh_limit;
        if (cfsmif.cmd_state == REFRESH) begin
            next_refresh_limit = cnt_t'(`tREFI);
            // late start shortens the next interval by the delay
            if (refresh_count > refresh_limit + cnt_t'(1)) begin
                if (lateness < cnt_t'(`tREFI)) begin
                    next_refresh_limit = cnt_t'(`tREFI) - lateness;
                end else begin
                    next_refresh_limit = '0;
                end
            end
        end
    end

    assign timif.rf_req = (refresh_count >= refresh_limit)
                        && (cfsmif.cmd_state != REFRESH);

    // a read burst drives rd_en for tBURST cycles in a row
    ap_rd_burst: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(timif.rd_en) |-> timif.rd_en [*`tBURST] ##1 !timif.rd_en)
        else $error("timing_signal: rd_en window is not tBURST cycles");

    // same for the write strobe
    ap_wr_burst: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(timif.wr_en) |-> timif.wr_en [*`tBURST] ##1 !timif.wr_en)
        else $error("timing_signal: wr_en window is not tBURST cycles");

endmodule

// ==== hw/command_fsm.sv ====
`timescale 1ns/100ps
`include "dram_settings.svh"

module command_fsm (
    input  logic                     CLK,
    input  logic                     nRST,
    timing_signal_if.cmd_ctrl        timif,
    command_fsm_if.fsm               cfsmif,
    output dram_cmd_pkg::dram_cmd_t  dram_cmd,
    output logic [`BANK_W-1:0]       dram_bank,
    output logic [`ROW_W-1:0]        dram_addr
);
    import dram_cmd_pkg::*;
    import dram_host_pkg::*;

    cmd_state_t state;
    cmd_state_t next_state;
    // request being executed
    dram_req_t  req_q;
    logic       take;

    // refresh blocks a new request in IDLE
    assign take = (state == IDLE) && !timif.rf_req && cfsmif.req_valid;
    assign cfsmif.req_take = take;
    assign cfsmif.cmd_state = state;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= POWERUP;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            req_q <= cfsmif.req;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            POWERUP: if (timif.tINIT_done) next_state = IDLE;
            IDLE: begin
                if (timif.rf_req) begin
                    next_state = REFRESH;
                end else if (cfsmif.req_valid) begin
                    next_state = ACTIVATE;
                end
            end
            ACTIVATE: next_state = ACTIVATING;
            ACTIVATING: begin
                if (timif.tACT_done) begin
                    next_state = req_q.is_write ? WRITE : READ;
                end
            end
            READ: next_state = READING;
            READING: if (timif.tRD_done) next_state = PRECHARGE;
            WRITE: next_state = WRITING;
            WRITING: if (timif.tWR_done) next_state = PRECHARGE;
            // closed page, every access ends with a precharge
            PRECHARGE: next_state = PRECHARGING;
            PRECHARGING: if (timif.tPRE_done) next_state = IDLE;
            REFRESH: next_state = REFRESHING;
            REFRESHING: if (timif.tREF_done) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // pin command only in issue states
    always_comb begin
        dram_cmd = NOP;
        dram_bank = '0;
        dram_addr = '0;
        case (state)
            ACTIVATE: begin
                dram_cmd = ACT;
                dram_bank = req_q.bank;
                dram_addr = req_q.row;
            end
            READ: begin
                dram_cmd = RD;
                dram_bank = req_q.bank;
                dram_addr[`COL_W-1:0] = req_q.col;
            end
            WRITE: begin
                dram_cmd = WR;
                dram_bank = req_q.bank;
                dram_addr[`COL_W-1:0] = req_q.col;
            end
            PRECHARGE: begin
                dram_cmd = PRE;
                dram_bank = req_q.bank;
            end
            REFRESH: dram_cmd = REF;
            default: begin
            end
        endcase
    end

    // row stays open at least tRAS before its precharge
    ap_tras: assert property (@(posedge CLK) disable iff (!nRST)
        (state == ACTIVATE) |=> (state != PRECHARGE) [*(`tRAS - 1)])
        else $error("command_fsm: precharge before tRAS");

endmodule

// ==== hw/apb_req_port.sv ====
`timescale 1ns/100ps

module apb_req_port (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [7:0]              PADDR,
    input  logic [31:0]             PWDATA,
    output logic [31:0]             PRDATA,
    output logic                    PREADY,
    output logic                    PSLVERR,
    command_fsm_if.host_port        cfsmif,
    input  logic                    init_done,
    input  logic                    rf_req
);
    import dram_cmd_pkg::*;
    import dram_host_pkg::*;

    logic access;
    logic busy;
    logic req_ok;

    // no wait states, every access completes in one cycle
    assign PREADY = 1'b1;
    assign access = PSEL && PENABLE;

    // a pending request counts as busy before the FSM takes it
    assign busy = cfsmif.req_valid || (cfsmif.cmd_state != IDLE);
    assign req_ok = access && PWRITE && (PADDR == REQ_ADDR) && !busy;

    always_comb begin
        PSLVERR = 1'b0;
        PRDATA = '0;
        if (access) begin
            case (PADDR)
                REQ_ADDR: begin
                    if (PWRITE) begin
                        PSLVERR = busy;
                    end else begin
                        PRDATA[REQ_W-1:0] = cfsmif.req;
                    end
                end
                STATUS_ADDR: begin
                    // read only
                    if (PWRITE) begin
                        PSLVERR = 1'b1;
                    end else begin
                        PRDATA[STAT_INIT] = init_done;
                        PRDATA[STAT_BUSY] = busy;
                        PRDATA[STAT_RFSH] = rf_req;
                    end
                end
                default: PSLVERR = 1'b1;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cfsmif.req_valid <= 1'b0;
        end else if (req_ok) begin
            cfsmif.req_valid <= 1'b1;
        end else if (cfsmif.req_take) begin
            cfsmif.req_valid <= 1'b0;
        end
    end

    // payload, written only when no request is pending
    always_ff @(posedge CLK) begin
        if (req_ok) begin
            cfsmif.req <= dram_req_t'(PWDATA[REQ_W-1:0]);
        end
    end

    // access phase always follows a setup phase
    ap_apb_setup: assert property (@(posedge CLK) disable iff (!nRST)
        PENABLE |-> PSEL && $past(PSEL && !PENABLE))
        else $error("apb_req_port: PENABLE without setup phase");

endmodule

// ==== hw/dram_ctrl_top.sv ====
`timescale 1ns/100ps
`include "dram_settings.svh"

module dram_ctrl_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [7:0]              PADDR,
    input  logic [31:0]             PWDATA,
    output logic [31:0]             PRDATA,
    output logic                    PREADY,
    output logic                    PSLVERR,
    output dram_cmd_pkg::dram_cmd_t dram_cmd,
    output logic [`BANK_W-1:0]      dram_bank,
    output logic [`ROW_W-1:0]       dram_addr,
    output logic                    dram_rd_en,
    output logic                    dram_wr_en
);

    timing_signal_if timif ();
    command_fsm_if   cfsmif ();

    // wait lengths, strobes and refresh pacing
    timing_signal u_timing_signal (
        .CLK    (CLK),
        .nRST   (nRST),
        .timif  (timif),
        .cfsmif (cfsmif)
    );

    command_fsm u_command_fsm (
        .CLK       (CLK),
        .nRST      (nRST),
        .timif     (timif),
        .cfsmif    (cfsmif),
        .dram_cmd  (dram_cmd),
        .dram_bank (dram_bank),
        .dram_addr (dram_addr)
    );

    // host side
    apb_req_port u_apb_req_port (
        .CLK       (CLK),
        .nRST      (nRST),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PWRITE    (PWRITE),
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PRDATA    (PRDATA),
        .PREADY    (PREADY),
        .PSLVERR   (PSLVERR),
        .cfsmif    (cfsmif),
        .init_done (timif.init_done),
        .rf_req    (timif.rf_req)
    );

    assign dram_rd_en = timif.rd_en;
    assign dram_wr_en = timif.wr_en;

endmodule

// ==== sim/dram_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "dram_settings.svh"

module dram_ctrl_tb;
    import dram_cmd_pkg::*;
    import dram_host_pkg::*;

    localparam int T_INIT = `tINIT;
    localparam int T_RL = (`tRL);
    localparam int T_WL = (`tWL);
    localparam int T_BURST = (`tBURST);
    localparam int T_RFC = (`tRFC);
    localparam int T_REFI = (`tREFI);
    // issue-to-issue gaps are the loaded wait plus one
    localparam int ACT_RW = (`tRCD) + 1;
    localparam int RD_PRE = T_RL + T_BURST + 1;
    localparam int WR_PRE = T_WL + T_BURST + (`tWR) + 1;
    localparam int LIMIT = T_INIT + 6 * (T_REFI + T_RFC) + 200;

    logic CLK = 1'b0;
    logic nRST;
    logic PSEL, PENABLE, PWRITE, PREADY, PSLVERR;
    logic [7:0] PADDR;
    logic [31:0] PWDATA, PRDATA;
    dram_cmd_t dram_cmd;
    logic [`BANK_W-1:0] dram_bank;
    logic [`ROW_W-1:0] dram_addr;
    logic dram_rd_en, dram_wr_en;

    int cyc = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    // commands seen on the pins, in order
    dram_cmd_t q_cmd[$];
    logic [`BANK_W-1:0] q_bank[$];
    logic [`ROW_W-1:0] q_addr[$];
    int q_cyc[$];
    // cycles with a strobe high
    int rd_q[$];
    int wr_q[$];

    dram_ctrl_top u_dram_ctrl_top (.*);

    always #20 CLK = ~CLK;

    // run limit
    always @(posedge CLK) begin
        cyc = cyc + 1;
        if (cyc >= LIMIT) begin
            $display("run stopped: cycle limit %0d reached", LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // pin outputs only follow the state, so the falling edge is a quiet point
    always @(negedge CLK) begin
        if (nRST) begin
            if (dram_cmd != NOP) begin
                q_cmd.push_back(dram_cmd);
                q_bank.push_back(dram_bank);
                q_addr.push_back(dram_addr);
                q_cyc.push_back(cyc);
                $display("cycle %0d: %s bank %0d addr 0x%0h", cyc, dram_cmd.name(),
                         dram_bank, dram_addr);
            end
            if (dram_rd_en) rd_q.push_back(cyc);
            if (dram_wr_en) wr_q.push_back(cyc);
        end
    end

    task automatic mismatch(string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic check_cmd(dram_cmd_t got, dram_cmd_t exp);
        if (got !== exp) mismatch($sformatf("command %s, expected %s", got.name(), exp.name()));
    endtask

    // row on ACT, column on RD and WR, bank on all access commands
    task automatic check_req_fields(dram_req_t exp, dram_cmd_t c, logic [`BANK_W-1:0] b,
                                    logic [`ROW_W-1:0] a);
        logic [`ROW_W-1:0] exp_a;
        exp_a = '0;
        if (c == ACT) exp_a = exp.row;
        if (c == RD || c == WR) exp_a = `ROW_W'(exp.col);
        if (b !== exp.bank) begin
            mismatch($sformatf("%s bank %0d, expected %0d", c.name(), b, exp.bank));
        end
        if (a !== exp_a) begin
            mismatch($sformatf("%s addr 0x%0h, expected 0x%0h", c.name(), a, exp_a));
        end
    endtask

    task automatic check_status(logic [31:0] got, logic init, logic busy, logic rfsh);
        if (got[2:0] !== {rfsh, busy, init}) begin
            mismatch($sformatf("status %b, expected %b", got[2:0], {rfsh, busy, init}));
        end
    endtask

    task automatic check_gap(string what, int got, int lo, int hi);
        if (got < lo || got > hi) begin
            mismatch($sformatf("%s gap %0d, expected %0d..%0d", what, got, lo, hi));
        end
    endtask

    // no wait states, so PREADY is high in every access phase
    task automatic check_ready(logic got);
        if (got !== 1'b1) mismatch("PREADY low in the access phase");
    endtask

    task automatic apb_write(logic [7:0] addr, logic [31:0] data, output logic err);
        @(negedge CLK);
        PSEL = 1'b1;
        PENABLE = 1'b0;
        PWRITE = 1'b1;
        PADDR = addr;
        PWDATA = data;
        @(negedge CLK);
        PENABLE = 1'b1;
        #5 err = PSLVERR;
        check_ready(PREADY);
        @(negedge CLK);
        PSEL = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apb_read(logic [7:0] addr, output logic [31:0] data);
        @(negedge CLK);
        PSEL = 1'b1;
        PENABLE = 1'b0;
        PWRITE = 1'b0;
        PADDR = addr;
        @(negedge CLK);
        PENABLE = 1'b1;
        #5 data = PRDATA;
        check_ready(PREADY);
        @(negedge CLK);
        PSEL = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic next_cmd(output dram_cmd_t c, output logic [`BANK_W-1:0] b,
                            output logic [`ROW_W-1:0] a, output int cy, input int max_wait);
        int waited;
        waited = 0;
        while (q_cmd.size() == 0 && waited < max_wait) begin
            @(posedge CLK);
            waited++;
        end
        if (q_cmd.size() == 0) begin
            errors++;
            $display("no DRAM command appeared within %0d cycles", max_wait);
            c = NOP;
            b = '0;
            a = '0;
            cy = cyc;
        end else begin
            c = q_cmd.pop_front();
            b = q_bank.pop_front();
            a = q_addr.pop_front();
            cy = q_cyc.pop_front();
        end
    endtask

    function automatic dram_req_t rand_req(logic is_write);
        dram_req_t r;
        r.is_write = is_write;
        r.bank = $urandom;
        r.row = $urandom;
        r.col = $urandom;
        return r;
    endfunction

    // REQ layout from bit 0: col, row, bank, is_write
    function automatic logic [31:0] req_word(dram_req_t r);
        return 32'(r.col) | (32'(r.row) << `COL_W) | (32'(r.bank) << (`COL_W + `ROW_W))
             | (32'(r.is_write) << (`COL_W + `ROW_W + `BANK_W));
    endfunction

    // ACT, RD or WR, PRE with their gaps and the strobe window
    task automatic expect_access(dram_req_t r, output int cy_act);
        dram_cmd_t c;
        logic [`BANK_W-1:0] b;
        logic [`ROW_W-1:0] a;
        int cy_rw;
        int cy;
        int first;
        rd_q.delete();
        wr_q.delete();
        next_cmd(c, b, a, cy_act, 300);
        check_cmd(c, ACT);
        check_req_fields(r, c, b, a);
        next_cmd(c, b, a, cy_rw, 20);
        check_cmd(c, r.is_write ? WR : RD);
        check_req_fields(r, c, b, a);
        check_gap("ACT to RD/WR", cy_rw - cy_act, ACT_RW, ACT_RW);
        next_cmd(c, b, a, cy, 20);
        check_cmd(c, PRE);
        check_req_fields(r, c, b, a);
        check_gap("RD/WR to PRE", cy - cy_rw, r.is_write ? WR_PRE : RD_PRE,
                  r.is_write ? WR_PRE : RD_PRE);
        first = cy_rw + (r.is_write ? T_WL : T_RL) + 1;
        if (r.is_write ? (wr_q.size() != T_BURST || rd_q.size() != 0)
                       : (rd_q.size() != T_BURST || wr_q.size() != 0)) begin
            mismatch($sformatf("strobe beats rd %0d wr %0d, expected %0d", rd_q.size(),
                               wr_q.size(), T_BURST));
        end else begin
            for (int i = 0; i < T_BURST; i++) begin
                cy = r.is_write ? wr_q[i] : rd_q[i];
                if (cy != first + i) mismatch($sformatf("strobe beat %0d at cycle %0d", i, cy));
            end
        end
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int n;
        n = 0;
        do begin
            apb_read(STATUS_ADDR, st);
            n++;
        end while (st[1] && n < 30);
        check_status(st, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic end_test(string name, int err_before);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    // ends with the request accepted in the cycle 'at'
    task automatic request_at(int at, dram_req_t r);
        logic err;
        while (cyc < at - 2) @(negedge CLK);
        apb_write(REQ_ADDR, req_word(r), err);
        if (err) mismatch("scheduled request refused");
    endtask

    initial begin
        logic [31:0] st;
        logic err;
        dram_req_t r;
        dram_req_t r2;
        dram_cmd_t c;
        logic [`BANK_W-1:0] b;
        logic [`ROW_W-1:0] a;
        int e0, init_cyc, cy_act, r1, r2c, r3, p, late, rn, n;

        void'($urandom(32'h53a139da));
        nRST = 1'b0;
        PSEL = 1'b0;
        PENABLE = 1'b0;
        PWRITE = 1'b0;
        PADDR = '0;
        PWDATA = '0;
        repeat (2) @(negedge CLK);
        nRST = 1'b1;

        // power-up
        e0 = errors;
        apb_read(STATUS_ADDR, st);
        check_status(st, 1'b0, 1'b1, 1'b0);
        n = 0;
        do begin
            apb_read(STATUS_ADDR, st);
            n++;
        end while (!st[0] && n < T_INIT);
        init_cyc = cyc;
        check_status(st, 1'b1, 1'b0, 1'b0);
        check_gap("reset to init_done", init_cyc, T_INIT, T_INIT + 10);
        if (q_cmd.size() != 0) mismatch("command issued during power-up");
        end_test("power-up", e0);

        for (int w = 0; w < 2; w++) begin
            e0 = errors;
            r = rand_req(w[0]);
            apb_write(REQ_ADDR, req_word(r), err);
            if (err) mismatch("valid request refused");
            expect_access(r, cy_act);
            wait_idle();
            end_test(w ? "write" : "read", e0);
        end

        // refusal
        e0 = errors;
        r = rand_req(1'b0);
        r2 = rand_req(1'b1);
        apb_write(REQ_ADDR, req_word(r), err);
        if (err) mismatch("first request refused");
        apb_write(REQ_ADDR, req_word(r2), err);
        if (!err) mismatch("request while busy was accepted");
        apb_write(8'h08, 32'h1, err);
        if (!err) mismatch("write to bad address was accepted");
        expect_access(r, cy_act);
        wait_idle();
        repeat (10) @(negedge CLK);
        if (q_cmd.size() != 0) mismatch("refused request was executed");
        end_test("refusal", e0);

        // refresh with the sequencer idle
        e0 = errors;
        next_cmd(c, b, a, r1, T_REFI + 20);
        check_cmd(c, REF);
        check_gap("init_done to REF", r1 - init_cyc, T_REFI - 1, T_REFI + 1);
        next_cmd(c, b, a, r2c, T_REFI + T_RFC + 20);
        check_cmd(c, REF);
        check_gap("REF to REF", r2c - r1, T_REFI + T_RFC + 2, T_REFI + T_RFC + 2);
        // count reaches the limit tRFC+1+tREFI after REF
        p = r2c + T_RFC + 1 + T_REFI;
        r = rand_req(1'b1);
        request_at(p, r);
        next_cmd(c, b, a, r3, 20);
        check_cmd(c, REF);
        check_gap("request to REF", r3 - p, 1, 1);
        expect_access(r, cy_act);
        check_gap("REF to ACT", cy_act - r3, T_RFC + 1, T_RFC + 5);
        end_test("refresh", e0);

        // late-refresh credit
        e0 = errors;
        p = r3 + T_RFC + 1 + T_REFI;
        r = rand_req(1'b1);
        request_at(p - 10, r);
        expect_access(r, cy_act);
        // refresh is overdue while the precharge finishes
        apb_read(STATUS_ADDR, st);
        check_status(st, 1'b1, 1'b1, 1'b1);
        next_cmd(c, b, a, late, 40);
        check_cmd(c, REF);
        late = late - p - 1;
        if (late <= 0) mismatch($sformatf("refresh not delayed, lateness %0d", late));
        r3 = p + 1 + late;
        next_cmd(c, b, a, rn, T_REFI + T_RFC + 20);
        check_cmd(c, REF);
        check_gap("late REF to next REF", rn - r3, T_REFI + T_RFC + 2 - late,
                  T_REFI + T_RFC + 2 - late);
        end_test("late refresh", e0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/dram_cmd_pkg.sv
hw/dram_host_pkg.sv
hw/timing_signal_if.sv
hw/command_fsm_if.sv
hw/flex_counter.sv
hw/timing_signal.sv
hw/command_fsm.sv
hw/apb_req_port.sv
hw/dram_ctrl_top.sv
sim/dram_ctrl_tb.sv
